/* build.f */
source/wb_pkg.sv
source/timer_pkg.sv
source/wb_periph_decoder.sv
source/mtimer.sv
source/wb_resp_mux.sv
source/periph_platform.sv
testbench/periph_platform_asserts.sv
testbench/tb_periph_platform.sv

/* run.sh */
#!/bin/sh
# compile and run the peripheral platform testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_periph_platform -f build.f -o tb_periph_platform
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_periph_platform +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
exit 0

/* source/mtimer.sv */
// machine timer with 64-bit mtime and mtimecmp
// byte-lane register writes, registered ack, read data and interrupt

module mtimer
import wb_pkg::*;
import timer_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       stb_i,
    input  logic       we_i,
    input  timer_reg_t reg_i,
    input  wb_sel_t    sel_i,
    input  wb_data_t   wdata_i,

    output logic       ack_o,
    output wb_data_t   rdata_o,
    output logic       irq_o
);

mtime_t   mtime_q;
mtime_t   mtimecmp_q;
logic     ack_q;
logic     irq_q;
wb_data_t rdata_q;
wb_data_t rd_val;
logic     wr;

// replace only the enabled bytes of a word
function automatic wb_data_t merge_bytes(wb_data_t old_v, wb_data_t new_v, wb_sel_t sel);
    wb_data_t res;
    res = old_v;
    for (int b = 0; b < $bits(wb_sel_t); b++) begin
        if (sel[b]) begin
            res[b*8 +: 8] = new_v[b*8 +: 8];
        end
    end
    return res;
endfunction

assign wr = stb_i && we_i;

// register content before any update at this edge
always_comb begin
    case (reg_i)
        REG_MTIME_LO:    rd_val = mtime_q[31:0];
        REG_MTIME_HI:    rd_val = mtime_q[63:32];
        REG_MTIMECMP_LO: rd_val = mtimecmp_q[31:0];
        default:         rd_val = mtimecmp_q[63:32];
    endcase
end

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        mtime_q    <= '0;
        mtimecmp_q <= '1;
        ack_q      <= 1'b0;
        irq_q      <= 1'b0;
    end else begin
        ack_q <= stb_i;
        // compare uses the values from before this edge
        irq_q <= mtime_q >= mtimecmp_q;

        // a write to either half holds off the increment
        if (wr && reg_i == REG_MTIME_LO) begin
            mtime_q[31:0] <= merge_bytes(mtime_q[31:0], wdata_i, sel_i);
        end else if (wr && reg_i == REG_MTIME_HI) begin
            mtime_q[63:32] <= merge_bytes(mtime_q[63:32], wdata_i, sel_i);
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end

        if (wr && reg_i == REG_MTIMECMP_LO) begin
            mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], wdata_i, sel_i);
        end else if (wr && reg_i == REG_MTIMECMP_HI) begin
            mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], wdata_i, sel_i);
        end
    end
end

// addressed register captured with the strobe
always_ff @(posedge clk_i) begin
    if (stb_i) begin
        rdata_q <= rd_val;
    end
end

assign ack_o   = ack_q;
assign rdata_o = rdata_q;
assign irq_o   = irq_q;

endmodule: mtimer

/* source/periph_platform.sv */
// peripheral platform top level
// address decoder, generated machine timers and response collector

module periph_platform
import wb_pkg::*;
import timer_pkg::*;
#(
    parameter int NUM_TIMERS = 4
)
(
    input  logic                  clk_i,
    input  logic                  rst_i,

    // host bus
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  wb_addr_t              wb_addr_i,
    input  wb_sel_t               wb_sel_i,
    input  wb_data_t              wb_wdata_i,

    output logic                  wb_ack_o,
    output logic                  wb_err_o,
    output wb_data_t              wb_rdata_o,

    // interrupts
    output logic [NUM_TIMERS-1:0] timer_irq_o,
    output logic                  irq_o
);

logic [NUM_TIMERS-1:0] timer_stb;
logic [NUM_TIMERS-1:0] timer_ack;
wb_data_t              timer_rdata [NUM_TIMERS];
logic                  dec_err;

wb_periph_decoder #(.NUM_TIMERS(NUM_TIMERS)) wb_periph_decoder_i
(
    .clk_i(clk_i),
    .rst_i(rst_i),

    .cyc_i(wb_cyc_i),
    .stb_i(wb_stb_i),
    .addr_i(wb_addr_i),

    .timer_stb_o(timer_stb),
    .err_o(dec_err)
);

// one timer per 16-byte window
for (genvar i = 0; i < NUM_TIMERS; i++) begin: gen_timer
    mtimer mtimer_i
    (
        .clk_i(clk_i),
        .rst_i(rst_i),

        .stb_i(timer_stb[i]),
        .we_i(wb_we_i),
        .reg_i(wb_addr_i[TIMER_REG_LSB +: $bits(timer_reg_t)]),
        .sel_i(wb_sel_i),
        .wdata_i(wb_wdata_i),

        .ack_o(timer_ack[i]),
        .rdata_o(timer_rdata[i]),
        .irq_o(timer_irq_o[i])
    );
end

wb_resp_mux #(.NUM_TIMERS(NUM_TIMERS)) wb_resp_mux_i
(
    .timer_ack_i(timer_ack),
    .timer_rdata_i(timer_rdata),
    .timer_irq_i(timer_irq_o),
    .dec_err_i(dec_err),

    .ack_o(wb_ack_o),
    .err_o(wb_err_o),
    .rdata_o(wb_rdata_o),
    .irq_o(irq_o)
);

endmodule: periph_platform

/* source/timer_pkg.sv */
// machine timer register map and counter type
// address field positions for timer index and register offset

package timer_pkg;

    // 64-bit counter and compare value
    typedef logic [63:0] mtime_t;

    // register offset within a timer window
    typedef logic [1:0] timer_reg_t;

    // word offsets, taken from address bits 3 to 2
    localparam timer_reg_t REG_MTIME_LO    = 2'd0;
    localparam timer_reg_t REG_MTIME_HI    = 2'd1;
    localparam timer_reg_t REG_MTIMECMP_LO = 2'd2;
    localparam timer_reg_t REG_MTIMECMP_HI = 2'd3;

    // lowest address bit of the register offset
    localparam int TIMER_REG_LSB = 2;

    // lowest address bit of the timer index, 16-byte window per timer
    localparam int TIMER_IDX_LSB = 4;

endpackage: timer_pkg

/* source/wb_periph_decoder.sv */
// timer address decoder
// one strobe per timer and a registered error for unmapped indices

module wb_periph_decoder
import wb_pkg::*;
import timer_pkg::*;
#(
    parameter int NUM_TIMERS = 4
)
(
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  wb_addr_t              addr_i,

    output logic [NUM_TIMERS-1:0] timer_stb_o,
    output logic                  err_o
);

// width of the index field, address bits 15 to 4
localparam int IDX_W = $bits(wb_addr_t) - TIMER_IDX_LSB;
localparam logic [IDX_W-1:0] NUM_IDX = IDX_W'(NUM_TIMERS);

logic             req;
logic [IDX_W-1:0] idx;
logic             mapped;
logic             err_q;

assign req    = cyc_i && stb_i;
assign idx    = addr_i[$bits(wb_addr_t)-1:TIMER_IDX_LSB];
assign mapped = idx < NUM_IDX;

// one-hot strobe, nothing raised for unmapped indices
always_comb begin
    for (int i = 0; i < NUM_TIMERS; i++) begin
        timer_stb_o[i] = req && (idx == IDX_W'(i));
    end
end

// err answers in the same cycle as a timer ack would
always_ff @(posedge clk_i) begin
    if (rst_i) begin
        err_q <= 1'b0;
    end else begin
        err_q <= req && !mapped;
    end
end

assign err_o = err_q;

endmodule: wb_periph_decoder

/* source/wb_pkg.sv */
// peripheral bus width types
// address, data and byte-lane select

package wb_pkg;

    // byte address on the peripheral bus
    typedef logic [15:0] wb_addr_t;

    // read and write data
    typedef logic [31:0] wb_data_t;

    // one enable per data byte
    typedef logic [3:0] wb_sel_t;

endpackage: wb_pkg

/* source/wb_resp_mux.sv */
// response collector for the timer bank
// merges acks and read data, passes decoder error, combines interrupts

module wb_resp_mux
import wb_pkg::*;
#(
    parameter int NUM_TIMERS = 4
)
(
    input  logic [NUM_TIMERS-1:0] timer_ack_i,
    input  wb_data_t              timer_rdata_i [NUM_TIMERS],
    input  logic [NUM_TIMERS-1:0] timer_irq_i,
    input  logic                  dec_err_i,

    output logic                  ack_o,
    output logic                  err_o,
    output wb_data_t              rdata_o,
    output logic                  irq_o
);

wb_data_t rdata;

// at most one timer acks per cycle
assign ack_o = |timer_ack_i;

// and-or select, zero when no timer acks
always_comb begin
    rdata = '0;
    for (int i = 0; i < NUM_TIMERS; i++) begin
        if (timer_ack_i[i]) begin
            rdata = rdata | timer_rdata_i[i];
        end
    end
end

assign rdata_o = rdata;

// decoder error is already aligned with the timer acks
assign err_o = dec_err_i;

// any pending timer raises the combined line
assign irq_o = |timer_irq_i;

endmodule: wb_resp_mux

/* testbench/periph_platform_asserts.sv */
// bus response assertions for the peripheral platform
// exclusive ack and err, one response per request, quiet after reset

module periph_platform_asserts #(
    parameter int NUM_TIMERS = 4
)
(
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  cyc_i,
    input logic                  stb_i,
    input logic                  ack_i,
    input logic                  err_i,
    input logic [NUM_TIMERS-1:0] timer_irq_i,
    input logic                  irq_i
);

timeunit 1ns;
timeprecision 100ps;

// number of failed assertions
int unsigned fail_count = 0;

logic req;

assign req = cyc_i && stb_i;

a_ack_err_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ack_i && err_i))
    else begin
        fail_count++;
        $error("ack and err were high in the same cycle");
    end

// exactly one of ack or err, one cycle after the request
a_one_response: assert property (@(posedge clk_i) disable iff (rst_i)
    req |=> (ack_i ^ err_i))
    else begin
        fail_count++;
        $error("accepted request got no single response one cycle later");
    end

a_no_spurious_response: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_i || err_i) |-> $past(req))
    else begin
        fail_count++;
        $error("response seen without a request in the previous cycle");
    end

a_quiet_after_reset: assert property (@(posedge clk_i)
    ($past(rst_i) && !rst_i) |-> (!ack_i && !err_i && timer_irq_i == '0 && !irq_i))
    else begin
        fail_count++;
        $error("outputs not low in the cycle after reset");
    end

endmodule: periph_platform_asserts

bind periph_platform periph_platform_asserts #(.NUM_TIMERS(NUM_TIMERS)) i_asserts
(
    .clk_i(clk_i),
    .rst_i(rst_i),
    .cyc_i(wb_cyc_i),
    .stb_i(wb_stb_i),
    .ack_i(wb_ack_o),
    .err_i(wb_err_o),
    .timer_irq_i(timer_irq_o),
    .irq_i(irq_o)
);

/* testbench/tb_periph_platform.sv */
// testbench for the peripheral platform
// random bus traffic against a timer model, checks and closing verdict

module tb_periph_platform
import wb_pkg::*;
import timer_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int NUM_TIMERS     = 4;
localparam int NUM_RANDOM     = 600;
localparam int NUM_DIRECTED   = 100;
localparam int TIMEOUT_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * 4 + 200;
localparam int SEED           = 47;

logic                  clk;
logic                  rst;
logic                  wb_cyc;
logic                  wb_stb;
logic                  wb_we;
wb_addr_t              wb_addr;
wb_sel_t               wb_sel;
wb_data_t              wb_wdata;
logic                  wb_ack;
logic                  wb_err;
wb_data_t              wb_rdata;
logic [NUM_TIMERS-1:0] timer_irq;
logic                  irq;

// reference state of every timer
mtime_t                model_mtime [NUM_TIMERS];
mtime_t                model_cmp [NUM_TIMERS];
logic [NUM_TIMERS-1:0] model_irq;
logic                  exp_ack;
logic                  exp_err;
wb_data_t              exp_rdata;

int cycle_count = 0;
int check_count = 0;
int error_count = 0;

periph_platform #(.NUM_TIMERS(NUM_TIMERS)) i_dut
(
    .clk_i(clk),
    .rst_i(rst),
    .wb_cyc_i(wb_cyc),
    .wb_stb_i(wb_stb),
    .wb_we_i(wb_we),
    .wb_addr_i(wb_addr),
    .wb_sel_i(wb_sel),
    .wb_wdata_i(wb_wdata),
    .wb_ack_o(wb_ack),
    .wb_err_o(wb_err),
    .wb_rdata_o(wb_rdata),
    .timer_irq_o(timer_irq),
    .irq_o(irq)
);

always #2 clk = ~clk;

always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("timeout, run stopped after %0d cycles", cycle_count);
        $display(">>> FAIL");
        $finish;
    end
end

// sel bit n enables data byte n
function automatic wb_data_t merge_lanes(wb_data_t old_v, wb_data_t new_v, wb_sel_t sel);
    wb_data_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_v & ~mask) | (new_v & mask);
endfunction

// one clock edge of the reference, using the request held on the bus
task automatic update_model();
    logic       req;
    logic       wr;
    int         idx;
    timer_reg_t rsel;
    req       = wb_cyc && wb_stb;
    idx       = int'(wb_addr[15:TIMER_IDX_LSB]);
    rsel      = wb_addr[3:2];
    exp_ack   = req && idx < NUM_TIMERS;
    exp_err   = req && idx >= NUM_TIMERS;
    exp_rdata = '0;
    if (exp_ack) begin
        case (rsel)
            REG_MTIME_LO:    exp_rdata = model_mtime[idx][31:0];
            REG_MTIME_HI:    exp_rdata = model_mtime[idx][63:32];
            REG_MTIMECMP_LO: exp_rdata = model_cmp[idx][31:0];
            default:         exp_rdata = model_cmp[idx][63:32];
        endcase
    end
    for (int t = 0; t < NUM_TIMERS; t++) begin
        // interrupt lags the compare by one edge
        model_irq[t] = model_mtime[t] >= model_cmp[t];
        wr = exp_ack && wb_we && idx == t;
        if (wr && rsel == REG_MTIME_LO) begin
            model_mtime[t][31:0] = merge_lanes(model_mtime[t][31:0], wb_wdata, wb_sel);
        end else if (wr && rsel == REG_MTIME_HI) begin
            model_mtime[t][63:32] = merge_lanes(model_mtime[t][63:32], wb_wdata, wb_sel);
        end else begin
            model_mtime[t] = model_mtime[t] + 64'd1;
        end
        if (wr && rsel == REG_MTIMECMP_LO) begin
            model_cmp[t][31:0] = merge_lanes(model_cmp[t][31:0], wb_wdata, wb_sel);
        end else if (wr && rsel == REG_MTIMECMP_HI) begin
            model_cmp[t][63:32] = merge_lanes(model_cmp[t][63:32], wb_wdata, wb_sel);
        end
    end
endtask

task automatic check_response();
    check_count++;
    assert (wb_ack === exp_ack) else begin
        error_count++;
        $display("[ERROR] wb_ack_o got %h expected %h", wb_ack, exp_ack);
    end
    assert (wb_err === exp_err) else begin
        error_count++;
        $display("[ERROR] wb_err_o got %h expected %h", wb_err, exp_err);
    end
    if (exp_ack) begin
        assert (wb_rdata === exp_rdata) else begin
            error_count++;
            $display("[ERROR] wb_rdata_o addr %h got %h expected %h",
                     wb_addr, wb_rdata, exp_rdata);
        end
    end
    assert (timer_irq === model_irq) else begin
        error_count++;
        $display("[ERROR] timer_irq_o got %h expected %h", timer_irq, model_irq);
    end
    assert (irq === |model_irq) else begin
        error_count++;
        $display("[ERROR] irq_o got %h expected %h", irq, |model_irq);
    end
endtask

// outputs are settled 1 ns after the edge, new inputs go on after the check
task automatic advance_edge();
    @(posedge clk);
    #1;
    update_model();
    check_response();
endtask

task automatic drive_request(input logic we, input int idx, input timer_reg_t rsel,
                             input wb_sel_t sel, input wb_data_t wdata);
    advance_edge();
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_addr  = {idx[11:0], rsel, 2'b00};
    wb_sel   = sel;
    wb_wdata = wdata;
endtask

task automatic drive_idle(input int cycles);
    for (int c = 0; c < cycles; c++) begin
        advance_edge();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    end
endtask

task automatic random_traffic();
    int         r;
    int         idx;
    timer_reg_t rsel;
    wb_data_t   wdata;
    for (int n = 0; n < NUM_RANDOM; n++) begin
        r = int'($urandom_range(0, 9));
        if (r == 0) begin
            drive_idle(1);
        end else if (r == 1) begin
            // cyc or stb alone is no request
            advance_edge();
            wb_cyc  = $urandom_range(0, 1) == 1;
            wb_stb  = !wb_cyc;
            wb_addr = wb_addr_t'($urandom_range(0, 65535));
        end else begin
            if ($urandom_range(0, 7) == 0) begin
                idx = int'($urandom_range(0, 4095));
            end else begin
                idx = int'($urandom_range(0, 5));
            end
            rsel  = timer_reg_t'($urandom_range(0, 3));
            wdata = $urandom;
            // small upper halves keep mtime and mtimecmp close
            if (rsel[0] && $urandom_range(0, 3) != 0) begin
                wdata = wb_data_t'($urandom_range(0, 1));
            end
            drive_request($urandom_range(0, 1) == 1, idx, rsel,
                          wb_sel_t'($urandom_range(0, 15)), wdata);
        end
    end
endtask

initial begin
    void'($urandom(SEED));
    clk      = 1'b0;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_addr  = '0;
    wb_sel   = '0;
    wb_wdata = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int t = 0; t < NUM_TIMERS; t++) begin
        model_mtime[t] = '0;
        model_cmp[t]   = '1;
    end
    model_irq = '0;

    // counters read back from reset, then lo into hi carry
    for (int t = 0; t < NUM_TIMERS; t++) begin
        drive_request(1'b0, t, REG_MTIME_LO, 4'hf, '0);
        drive_request(1'b0, t, REG_MTIME_HI, 4'hf, '0);
    end
    drive_request(1'b1, 0, REG_MTIME_LO, 4'hf, 32'hffff_fff8);
    drive_idle(16);
    drive_request(1'b0, 0, REG_MTIME_LO, 4'hf, '0);
    drive_request(1'b0, 0, REG_MTIME_HI, 4'hf, '0);

    // timer 1 fires, then compare moves above mtime
    drive_request(1'b1, 1, REG_MTIMECMP_HI, 4'hf, '0);
    drive_request(1'b1, 1, REG_MTIMECMP_LO, 4'hf, 32'h0000_0040);
    drive_idle(48);
    drive_request(1'b1, 1, REG_MTIMECMP_HI, 4'hf, 32'h0000_0001);
    drive_idle(4);

    random_traffic();
    drive_idle(2);

    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, i_dut.i_asserts.fail_count);
    if (error_count == 0 && i_dut.i_asserts.fail_count == 0) begin
        $display(">>> PASS");
    end else begin
        $display(">>> FAIL");
    end
    $finish;
end

endmodule: tb_periph_platform
